// ==== sim/loopback_cases.txt ====
# lane tag(hex) data_beats keep_of_last(hex) ready(0 high, 1 random low, 2 held low)
# consecutive lines with the same ready value run together, both lanes in parallel
0 0a5 1 ff 0
1 13c 3 0f 0
0 1ff 2 01 0
1 000 4 ff 0
0 0f1 5 3f 0
1 1a2 2 ff 0
0 055 3 07 1
1 0aa 6 ff 1
0 123 4 7f 1
1 1e0 1 03 1
0 04c 7 ff 1
1 19b 3 1f 1
0 0c3 20 ff 2
0 0d4 2 ff 0
1 1f0 20 0f 2
1 0e1 2 ff 1
0 16d 3 ff 1

// ==== sources.f ====
+incdir+common
common/loopback_pkg.sv
header_remover/header_remover.sv
verilog/axis_fifo.sv
verilog/loopback_msg_fifo.sv
verilog/frame_merge.sv
verilog/loopback_top.sv
sim/tb_clock.sv
sim/loopback_monitor.sv
sim/loopback_chk.sv
sim/loopback_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= loopback_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' sources.f)
HEADERS := $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

run: $(SIM_BIN) sim/loopback_cases.txt
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/loopback_tb.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module loopback_tb;
    import loopback_pkg::*;

    localparam int MAX_CASES  = 64;
    localparam int WAIT_LIMIT = 2000;

    logic     clk;
    logic     reset;
    lb_data_t s0_tdata;
    lb_keep_t s0_tkeep;
    logic     s0_tvalid;
    logic     s0_tlast;
    logic     s0_tready;
    lb_data_t s1_tdata;
    lb_keep_t s1_tkeep;
    logic     s1_tvalid;
    logic     s1_tlast;
    logic     s1_tready;
    lb_data_t m_tdata;
    lb_keep_t m_tkeep;
    logic     m_tvalid;
    logic     m_tlast;
    lb_tag_t  m_tdest;
    lb_port_t m_tuser;
    logic     m_tready;

    int          case_lane  [MAX_CASES];
    int          case_tag   [MAX_CASES];
    int          case_beats [MAX_CASES];
    int          case_keep  [MAX_CASES];
    int          case_ready [MAX_CASES];  // 0 high, 1 random low, 2 held low
    int          n_cases;
    int          data_taken [2];
    int          beats_expected;
    logic        drivers_done;
    logic [15:0] lfsr;

    tb_clock clock_gen (.clk(clk));

    loopback_top i_dut (.*);

    loopback_monitor i_mon (
        .clk       (clk),
        .reset     (reset),
        .m_tdata   (m_tdata),
        .m_tkeep   (m_tkeep),
        .m_tdest   (m_tdest),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tuser   (m_tuser),
        .m_tready  (m_tready),
        .s0_tready (s0_tready),
        .s1_tready (s1_tready)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] word;
        logic        fb;
        int          i;
        word = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            word = {word[62:0], fb};
        end
        return word;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic read_cases();
        int    fd;
        int    lane;
        int    tag;
        int    beats;
        int    keep;
        int    ready;
        string line;
        n_cases = 0;
        fd = $fopen("sim/loopback_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/loopback_cases.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%d %h %d %h %d", lane, tag, beats, keep, ready) == 5) begin
                    case_lane[n_cases]  = lane;
                    case_tag[n_cases]   = tag;
                    case_beats[n_cases] = beats;
                    case_keep[n_cases]  = keep;
                    case_ready[n_cases] = ready;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic lane_ready(input int lane);
        return (lane == 0) ? s0_tready : s1_tready;
    endfunction

    task automatic drive_lane(input int lane, input logic valid, input lb_data_t data,
                              input lb_keep_t keep, input logic last);
        if (lane == 0) begin
            s0_tvalid = valid;
            s0_tdata  = data;
            s0_tkeep  = keep;
            s0_tlast  = last;
        end else begin
            s1_tvalid = valid;
            s1_tdata  = data;
            s1_tkeep  = keep;
            s1_tlast  = last;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input int lane, input lb_data_t data, input lb_keep_t keep,
                             input logic last, input logic is_data);
        int waited;
        waited = 0;
        drive_lane(lane, 1'b1, data, keep, last);
        #1;
        while (!lane_ready(lane) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!lane_ready(lane)) begin
            stop_on_timeout($sformatf("s%0d_tready to accept a beat", lane));
        end else begin
            if (is_data) begin
                data_taken[lane]++;
            end
            @(negedge clk);
        end
    endtask

    task automatic send_frame(input int idx);
        lb_data_t beats [$];
        lb_keep_t keeps [$];
        lb_data_t header;
        lb_tag_t  tag;
        int       lane;
        int       n;
        lane   = case_lane[idx];
        tag    = lb_tag_t'(case_tag[idx]);
        header = lfsr_bits(64);
        header[`LB_TAG_WIDTH-1:0] = tag;
        for (n = 0; n < case_beats[idx]; n++) begin
            beats.push_back(lfsr_bits(64));
            keeps.push_back((n == case_beats[idx] - 1) ? lb_keep_t'(case_keep[idx]) : '1);
            i_mon.expect_beat(lane, beats[n], keeps[n], tag, n == case_beats[idx] - 1);
            beats_expected++;
        end
        send_beat(lane, header, '1, 1'b0, 1'b0);
        for (n = 0; n < case_beats[idx]; n++) begin
            send_beat(lane, beats[n], keeps[n], n == case_beats[idx] - 1, 1'b1);
        end
        drive_lane(lane, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic run_lane(input int lane, input int first, input int last);
        int i;
        for (i = first; i <= last; i++) begin
            if (case_lane[i] == lane) begin
                send_frame(i);
            end
        end
    endtask

    task automatic drive_ready(input int mode, input int stall_lane);
        int waited;
        int low_run;
        waited  = 0;
        low_run = 0;
        if (mode == 2) begin
            m_tready = 1'b0;
            while (low_run < 4 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                #1;
                low_run = lane_ready(stall_lane) ? 0 : low_run + 1;
                waited++;
            end
            if (low_run < 4) begin
                stop_on_timeout($sformatf("s%0d_tready to drop with a full FIFO", stall_lane));
            end else begin
                i_mon.compare_count($sformatf("lane %0d beats taken before stall", stall_lane),
                                    data_taken[stall_lane], `LB_FIFO_DEPTH + 1);
                @(negedge clk);
            end
        end
        waited = 0;
        while (!(drivers_done && i_mon.beats_seen == beats_expected) && waited < WAIT_LIMIT) begin
            m_tready = (mode == 1) ? (lfsr_bits(2) != 64'd0) : 1'b1;  // low one cycle in four
            @(negedge clk);
            waited++;
        end
        if (!(drivers_done && i_mon.beats_seen == beats_expected)) begin
            stop_on_timeout("all expected beats to leave the DUT");
        end else begin
            m_tready = 1'b1;
        end
    endtask

    task automatic run_batch(input int first, input int last);
        drivers_done  = 1'b0;
        data_taken[0] = 0;
        data_taken[1] = 0;
        fork
            begin
                fork
                    run_lane(0, first, last);
                    run_lane(1, first, last);
                join
                drivers_done = 1'b1;
            end
            drive_ready(case_ready[first], case_lane[first]);
        join
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    initial begin
        int first;
        int last;
        reset          = 1'b1;
        m_tready       = 1'b1;
        lfsr           = 16'd84;
        beats_expected = 0;
        drivers_done   = 1'b0;
        drive_lane(0, 1'b0, '0, '0, 1'b0);
        drive_lane(1, 1'b0, '0, '0, 1'b0);
        read_cases();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        first = 0;
        while (first < n_cases) begin
            last = first;  // consecutive lines with one ready pattern run together
            while (last + 1 < n_cases && case_ready[last + 1] == case_ready[first]) begin
                last++;
            end
            run_batch(first, last);
            first = last + 1;
        end
        $display("%0d tests, %0d errors", i_mon.test_count, i_mon.error_count);
        if (i_mon.error_count == 0 && n_cases > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/loopback_chk.sv ====
`timescale 1ns/10ps

module loopback_chk (
    input  logic                   clk,
    input  logic                   reset,
    input  loopback_pkg::lb_data_t m_tdata,
    input  logic                   m_tvalid,
    input  logic                   m_tlast,
    input  loopback_pkg::lb_port_t m_tuser,
    input  logic                   m_tready
);
    logic stall;
    logic mid_frame;

    assign stall     = m_tvalid && !m_tready;
    assign mid_frame = m_tvalid && !(m_tready && m_tlast);  // frame goes on next cycle

    a_valid_hold: assert property (@(posedge clk) disable iff (reset) stall |=> m_tvalid)
        else $error("m_tvalid fell without a transfer");

    a_data_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(m_tdata))
        else $error("m_tdata changed while the output was stalled");

    a_user_frame: assert property (@(posedge clk) disable iff (reset)
        mid_frame |=> $stable(m_tuser))
        else $error("m_tuser changed within a frame");

endmodule

bind loopback_top loopback_chk i_chk (
    .clk      (clk),
    .reset    (reset),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast),
    .m_tuser  (m_tuser),
    .m_tready (m_tready)
);

// ==== sim/loopback_monitor.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module loopback_monitor (
    input  logic                   clk,
    input  logic                   reset,
    input  loopback_pkg::lb_data_t m_tdata,
    input  loopback_pkg::lb_keep_t m_tkeep,
    input  loopback_pkg::lb_tag_t  m_tdest,
    input  logic                   m_tlast,
    input  logic                   m_tvalid,
    input  loopback_pkg::lb_port_t m_tuser,
    input  logic                   m_tready,
    input  logic                   s0_tready,
    input  logic                   s1_tready
);
    import loopback_pkg::*;

    // last, dest, keep, data
    typedef logic [`LB_DATA_WIDTH+`LB_KEEP_WIDTH+`LB_TAG_WIDTH:0] beat_t;

    beat_t exp_q0 [$];
    beat_t exp_q1 [$];
    int    test_count   = 0;
    int    error_count  = 0;
    int    beats_seen   = 0;
    int    frame_beats  = 0;
    int    frame_errors = 0;
    int    reset_errors = 0;
    int    cur_lane     = 0;
    logic  in_frame     = 1'b0;
    logic  reset_q;

    task automatic expect_beat(input int lane, input lb_data_t data, input lb_keep_t keep,
                               input lb_tag_t dest, input logic last);
        if (lane == 0) begin
            exp_q0.push_back({last, dest, keep, data});
        end else begin
            exp_q1.push_back({last, dest, keep, data});
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        frame_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic compare_count(input string what, input int got, input int expected);
        test_count++;
        if (got != expected) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, expected));
        end else begin
            $display("%s: %0d ok", what, got);
        end
        frame_errors = 0;
    endtask

    task automatic check_beat();
        int       lane;
        beat_t    exp;
        lb_data_t e_data;
        lb_keep_t e_keep;
        lb_tag_t  e_dest;
        logic     e_last;
        lane = int'(m_tuser) - `LB_FIRST_PORT;
        beats_seen++;
        if (lane != 0 && lane != 1) begin
            report_error($sformatf("m_tuser %0d names no lane", m_tuser));
        end else if (in_frame && lane != cur_lane) begin
            report_error($sformatf("port %0d beat inside a frame of another port", m_tuser));
        end else if ((lane == 0 && exp_q0.size() == 0) || (lane == 1 && exp_q1.size() == 0)) begin
            report_error($sformatf("beat on port %0d with no frame expected", m_tuser));
        end else begin
            if (lane == 0) begin
                exp = exp_q0.pop_front();
            end else begin
                exp = exp_q1.pop_front();
            end
            {e_last, e_dest, e_keep, e_data} = exp;
            if ({m_tlast, m_tdest, m_tkeep, m_tdata} !== exp) begin
                report_error($sformatf("port %0d got %h %h %h %b, expected %h %h %h %b",
                    m_tuser, m_tdata, m_tkeep, m_tdest, m_tlast,
                    e_data, e_keep, e_dest, e_last));
            end
        end
        frame_beats++;
        cur_lane = lane;
        in_frame = !m_tlast;
        if (m_tlast) begin
            test_count++;
            $display("frame on port %0d tag %h: %0d beats %s", m_tuser, m_tdest, frame_beats,
                     frame_errors == 0 ? "ok" : "wrong");
            frame_beats  = 0;
            frame_errors = 0;
        end
    endtask

    always @(posedge clk) begin
        reset_q <= reset;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sampled midway between the falling and rising edge
    always @(negedge clk) begin
        #1;
        if (reset_q === 1'b1) begin
            if (m_tvalid !== 1'b0 || s0_tready !== 1'b1 || s1_tready !== 1'b1) begin
                reset_errors++;
                report_error($sformatf("reset state m_tvalid %b s0_tready %b s1_tready %b",
                             m_tvalid, s0_tready, s1_tready));
            end
            if (!reset) begin  // first cycle out of reset
                test_count++;
                $display("reset state: %s", reset_errors == 0 ? "ok" : "wrong");
                frame_errors = 0;
            end
        end else if (!reset && m_tvalid === 1'b1 && m_tready === 1'b1) begin
            check_beat();
        end
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;  // 4 ns period
    end

endmodule

// ==== verilog/loopback_top.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module loopback_top (
    input  logic                   clk,
    input  logic                   reset,

    input  loopback_pkg::lb_data_t s0_tdata,
    input  loopback_pkg::lb_keep_t s0_tkeep,
    input  logic                   s0_tvalid,
    input  logic                   s0_tlast,
    output logic                   s0_tready,

    input  loopback_pkg::lb_data_t s1_tdata,
    input  loopback_pkg::lb_keep_t s1_tkeep,
    input  logic                   s1_tvalid,
    input  logic                   s1_tlast,
    output logic                   s1_tready,

    output loopback_pkg::lb_data_t m_tdata,
    output loopback_pkg::lb_keep_t m_tkeep,
    output logic                   m_tvalid,
    output logic                   m_tlast,
    output loopback_pkg::lb_tag_t  m_tdest,
    output loopback_pkg::lb_port_t m_tuser,
    input  logic                   m_tready
);
    import loopback_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane streams between buffering and merge
    lb_data_t l0_tdata;
    lb_keep_t l0_tkeep;
    lb_tag_t  l0_tdest;
    logic     l0_tlast;
    logic     l0_tvalid;
    logic     l0_tready;

    lb_data_t l1_tdata;
    lb_keep_t l1_tkeep;
    lb_tag_t  l1_tdest;
    logic     l1_tlast;
    logic     l1_tvalid;
    logic     l1_tready;

    loopback_msg_fifo msg_fifo_inst (.*);  // port names match the wires

    frame_merge merge_inst (.*);

endmodule

// ==== verilog/frame_merge.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module frame_merge (
    input  logic                   clk,
    input  logic                   reset,

    input  loopback_pkg::lb_data_t l0_tdata,
    input  loopback_pkg::lb_keep_t l0_tkeep,
    input  loopback_pkg::lb_tag_t  l0_tdest,
    input  logic                   l0_tlast,
    input  logic                   l0_tvalid,
    output logic                   l0_tready,

    input  loopback_pkg::lb_data_t l1_tdata,
    input  loopback_pkg::lb_keep_t l1_tkeep,
    input  loopback_pkg::lb_tag_t  l1_tdest,
    input  logic                   l1_tlast,
    input  logic                   l1_tvalid,
    output logic                   l1_tready,

    output loopback_pkg::lb_data_t m_tdata,
    output loopback_pkg::lb_keep_t m_tkeep,
    output loopback_pkg::lb_tag_t  m_tdest,
    output logic                   m_tlast,
    output logic                   m_tvalid,
    output loopback_pkg::lb_port_t m_tuser,
    input  logic                   m_tready
);
    import loopback_pkg::*;

    logic locked;       // a frame is in progress
    logic grant;        // lane held while locked
    logic last_served;
    logic pick;
    logic sel;
    logic xfer;

    // free choice at a frame start, other lane first
    always_comb begin
        if (l0_tvalid && l1_tvalid) begin
            pick = !last_served;
        end else begin
            pick = l1_tvalid;
        end
    end

    assign sel  = locked ? grant : pick;
    assign xfer = m_tvalid && m_tready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output steering
    assign m_tdata   = sel ? l1_tdata  : l0_tdata;
    assign m_tkeep   = sel ? l1_tkeep  : l0_tkeep;
    assign m_tdest   = sel ? l1_tdest  : l0_tdest;
    assign m_tlast   = sel ? l1_tlast  : l0_tlast;
    assign m_tvalid  = sel ? l1_tvalid : l0_tvalid;
    assign m_tuser   = lb_port_t'(`LB_FIRST_PORT) + lb_port_t'(sel);
    assign l0_tready = m_tready && !sel;
    assign l1_tready = m_tready && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked      <= 1'b0;
            grant       <= 1'b0;
            last_served <= 1'b1;  // lane 0 goes first
        end else if (xfer && m_tlast) begin
            locked      <= 1'b0;
            last_served <= sel;
        end else if (m_tvalid && !locked) begin
            locked <= 1'b1;  // hold choice even if the beat stalls
            grant  <= pick;
        end
    end

endmodule

// ==== verilog/loopback_msg_fifo.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module loopback_msg_fifo (
    input  logic                   clk,
    input  logic                   reset,

    input  loopback_pkg::lb_data_t s0_tdata,
    input  loopback_pkg::lb_keep_t s0_tkeep,
    input  logic                   s0_tvalid,
    input  logic                   s0_tlast,
    output logic                   s0_tready,

    input  loopback_pkg::lb_data_t s1_tdata,
    input  loopback_pkg::lb_keep_t s1_tkeep,
    input  logic                   s1_tvalid,
    input  logic                   s1_tlast,
    output logic                   s1_tready,

    output loopback_pkg::lb_data_t l0_tdata,
    output loopback_pkg::lb_keep_t l0_tkeep,
    output loopback_pkg::lb_tag_t  l0_tdest,
    output logic                   l0_tlast,
    output logic                   l0_tvalid,
    input  logic                   l0_tready,

    output loopback_pkg::lb_data_t l1_tdata,
    output loopback_pkg::lb_keep_t l1_tkeep,
    output loopback_pkg::lb_tag_t  l1_tdest,
    output logic                   l1_tlast,
    output logic                   l1_tvalid,
    input  logic                   l1_tready
);
    import loopback_pkg::*;

    lb_data_t [`LB_PORT_COUNT-1:0] in_tdata;
    lb_keep_t [`LB_PORT_COUNT-1:0] in_tkeep;
    logic     [`LB_PORT_COUNT-1:0] in_tvalid;
    logic     [`LB_PORT_COUNT-1:0] in_tlast;
    logic     [`LB_PORT_COUNT-1:0] in_tready;

    lb_data_t [`LB_PORT_COUNT-1:0] out_tdata;
    lb_keep_t [`LB_PORT_COUNT-1:0] out_tkeep;
    lb_tag_t  [`LB_PORT_COUNT-1:0] out_tdest;
    logic     [`LB_PORT_COUNT-1:0] out_tlast;
    logic     [`LB_PORT_COUNT-1:0] out_tvalid;
    logic     [`LB_PORT_COUNT-1:0] out_tready;

    // lane 1 in the upper slot
    assign in_tdata   = {s1_tdata, s0_tdata};
    assign in_tkeep   = {s1_tkeep, s0_tkeep};
    assign in_tvalid  = {s1_tvalid, s0_tvalid};
    assign in_tlast   = {s1_tlast, s0_tlast};
    assign out_tready = {l1_tready, l0_tready};

    assign {s1_tready, s0_tready} = in_tready;
    assign {l1_tdata, l0_tdata}   = out_tdata;
    assign {l1_tkeep, l0_tkeep}   = out_tkeep;
    assign {l1_tdest, l0_tdest}   = out_tdest;
    assign {l1_tlast, l0_tlast}   = out_tlast;
    assign {l1_tvalid, l0_tvalid} = out_tvalid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one independent lane per input port
    for (genvar i = 0; i < `LB_PORT_COUNT; i++) begin : g_lane
        lb_data_t hr_tdata;
        lb_keep_t hr_tkeep;
        lb_tag_t  hr_tdest;
        logic     hr_tvalid;
        logic     hr_tlast;
        logic     hr_tready;

        header_remover dest_remover (
            .clk      (clk),
            .reset    (reset),
            .s_tdata  (in_tdata[i]),
            .s_tkeep  (in_tkeep[i]),
            .s_tvalid (in_tvalid[i]),
            .s_tlast  (in_tlast[i]),
            .s_tready (in_tready[i]),
            .m_tdata  (hr_tdata),
            .m_tkeep  (hr_tkeep),
            .m_tdest  (hr_tdest),
            .m_tvalid (hr_tvalid),
            .m_tlast  (hr_tlast),
            .m_tready (hr_tready)
        );

        axis_fifo #(
            .DEPTH(`LB_FIFO_DEPTH)
        ) axis_fifo_inst (
            .clk      (clk),
            .reset    (reset),
            .s_tdata  (hr_tdata),
            .s_tkeep  (hr_tkeep),
            .s_tdest  (hr_tdest),  // tag rides along with each beat
            .s_tlast  (hr_tlast),
            .s_tvalid (hr_tvalid),
            .s_tready (hr_tready),
            .m_tdata  (out_tdata[i]),
            .m_tkeep  (out_tkeep[i]),
            .m_tdest  (out_tdest[i]),
            .m_tlast  (out_tlast[i]),
            .m_tvalid (out_tvalid[i]),
            .m_tready (out_tready[i])
        );
    end

endmodule

// ==== verilog/axis_fifo.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module axis_fifo #(
    parameter int DEPTH = `LB_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   reset,

    input  loopback_pkg::lb_data_t s_tdata,
    input  loopback_pkg::lb_keep_t s_tkeep,
    input  loopback_pkg::lb_tag_t  s_tdest,
    input  logic                   s_tlast,
    input  logic                   s_tvalid,
    output logic                   s_tready,

    output loopback_pkg::lb_data_t m_tdata,
    output loopback_pkg::lb_keep_t m_tkeep,
    output loopback_pkg::lb_tag_t  m_tdest,
    output logic                   m_tlast,
    output logic                   m_tvalid,
    input  logic                   m_tready
);
    import loopback_pkg::*;

    localparam int AW = $clog2(DEPTH);

    lb_data_t    mem_data [DEPTH];
    lb_keep_t    mem_keep [DEPTH];
    lb_tag_t     mem_dest [DEPTH];
    logic        mem_last [DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;   // head entry, held until taken at the output
    logic [AW:0] rd_next;
    logic        full;
    logic        wr_en;
    logic        take;
    logic        load;
    logic        stored;

    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign s_tready = !full;
    assign wr_en    = s_tvalid && !full;
    assign take     = m_tvalid && m_tready;
    assign rd_next  = take ? rd_ptr + 1'b1 : rd_ptr;
    assign load     = !m_tvalid || take;   // output stage free next cycle
    assign stored   = (rd_next != wr_ptr); // next head already in memory

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[AW-1:0]] <= s_tdata;
            mem_keep[wr_ptr[AW-1:0]] <= s_tkeep;
            mem_dest[wr_ptr[AW-1:0]] <= s_tdest;
            mem_last[wr_ptr[AW-1:0]] <= s_tlast;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_next;
            if (load) begin
                m_tvalid <= stored || wr_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (stored) begin
                m_tdata <= mem_data[rd_next[AW-1:0]];
                m_tkeep <= mem_keep[rd_next[AW-1:0]];
                m_tdest <= mem_dest[rd_next[AW-1:0]];
                m_tlast <= mem_last[rd_next[AW-1:0]];
            end else begin
                m_tdata <= s_tdata;  // bypass when empty
                m_tkeep <= s_tkeep;
                m_tdest <= s_tdest;
                m_tlast <= s_tlast;
            end
        end
    end

endmodule

// ==== header_remover/header_remover.sv ====
`timescale 1ns/10ps
`include "loopback_macros.svh"

module header_remover (
    input  logic                   clk,
    input  logic                   reset,

    input  loopback_pkg::lb_data_t s_tdata,
    input  loopback_pkg::lb_keep_t s_tkeep,
    input  logic                   s_tvalid,
    input  logic                   s_tlast,
    output logic                   s_tready,

    output loopback_pkg::lb_data_t m_tdata,
    output loopback_pkg::lb_keep_t m_tkeep,
    output loopback_pkg::lb_tag_t  m_tdest,
    output logic                   m_tvalid,
    output logic                   m_tlast,
    input  logic                   m_tready
);
    import loopback_pkg::*;

    typedef enum logic {
        HDR_WAIT,
        HDR_BODY
    } hdr_state_t;

    hdr_state_t state;
    lb_tag_t    tag_q;
    logic       accept;
    logic       hdr_beat;
    logic       body_beat;

    assign s_tready  = !m_tvalid || m_tready;  // register empty or draining
    assign accept    = s_tvalid && s_tready;
    assign hdr_beat  = accept && (state == HDR_WAIT);
    assign body_beat = accept && (state == HDR_BODY);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame position
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HDR_WAIT;
        end else if (accept) begin
            case (state)
                HDR_WAIT: begin
                    state <= HDR_BODY;  // header dropped here
                end
                HDR_BODY: begin
                    if (s_tlast) begin
                        state <= HDR_WAIT;
                    end
                end
                default: begin
                    state <= HDR_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            tag_q <= s_tdata[`LB_TAG_WIDTH-1:0];  // low bits of header
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            m_tvalid <= 1'b0;
        end else if (body_beat) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (body_beat) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
            m_tdest <= tag_q;  // tag of the current frame
        end
    end

endmodule

// ==== common/loopback_pkg.sv ====
`include "loopback_macros.svh"

package loopback_pkg;

    // one beat of the stream
    typedef logic [`LB_DATA_WIDTH-1:0] lb_data_t;

    // byte enables of a beat
    typedef logic [`LB_KEEP_WIDTH-1:0] lb_keep_t;

    // destination tag from the header
    typedef logic [`LB_TAG_WIDTH-1:0]  lb_tag_t;

    // output port number
    typedef logic [`LB_PORT_WIDTH-1:0] lb_port_t;

endpackage

// ==== common/loopback_macros.svh ====
`ifndef LOOPBACK_MACROS_SVH
`define LOOPBACK_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream widths
`define LB_DATA_WIDTH 64
`define LB_KEEP_WIDTH 8
`define LB_TAG_WIDTH  9   // 5 slot/msg bits + 4 core bits
`define LB_PORT_WIDTH 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lanes and buffering
`define LB_PORT_COUNT 2
`define LB_FIRST_PORT 2   // port number of lane 0
`define LB_FIFO_DEPTH 16  // beats per lane

`endif
